//--- sim/blur_testdata.txt
// per test: 6 image rows, then 6 expected blurred rows, one 128-bit row per line
// pixel 15 in the leftmost two digits, pixel 0 in the rightmost two
10101010101010101010101010101010
10101010101010101010101010101010
10101010101010101010101010101010
10101010101010101010101010101010
10101010101010101010101010101010
10101010101010101010101010101010
090c0c0c0c0c0c0c0c0c0c0c0c0c0c09
0c1010101010101010101010101010 0c
0c10101010101010101010101010100c
0c10101010101010101010101010100c
0c10101010101010101010101010100c
090c0c0c0c0c0c0c0c0c0c0c0c0c0c09
ff000000000000000000000000000000
00000000000000000000000000000000
0000000000000000000000f000000000
00000000000000000000000000000000
00000000800000000000000000000000
000000000000000000000000000000f0
40200000000000000000000000000000
201000000000000000000f1e0f000000
000000000000000000001e3c1e000000
000000081008000000000f1e0f000000
00000010201000000000000000000f1e
00000008100800000000000000001e3c

//--- tb.f
hw/blur_pkg.sv
hw/scan_counter.sv
hw/blur_fsm.sv
hw/line_buffer.sv
hw/gauss_3x3.sv
hw/strip_merge.sv
hw/gaussian_blur.sv
sim/tb_gaussian_blur.sv

//--- Makefile
TOP := tb_gaussian_blur

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f tb.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "Simulation failed" sim.log; then echo "run FAILED"; exit 1; fi
	@grep -q "Simulation passed" sim.log || (echo "run did not complete"; exit 1)

clean:
	rm -rf obj_dir sim.log

//--- sim/tb_gaussian_blur.sv
module tb_gaussian_blur;
  import blur_pkg::*;

  localparam int CLK_PERIOD = 8;
  localparam int STRIPS     = IMG_W / STRIP_PX;
  localparam int ADDR_W     = $clog2(IMG_H + 1);
  localparam int MEM_DEPTH  = 1 << ADDR_W;
  localparam int RUN_CYCLES = STRIPS * (2 + 4 * IMG_H) + 2;
  localparam int NUM_TESTS  = 3;
  // preset, start and idle cycles around each run
  localparam int RUN_SLACK  = 24;
  localparam int WATCHDOG_TIME = NUM_TESTS * 2 * (RUN_CYCLES + RUN_SLACK) * CLK_PERIOD;

  logic              clk;
  logic              rst_n;
  logic              start;
  logic              done;
  logic [ADDR_W-1:0] img_addr;
  logic [ADDR_W-1:0] blur_addr;
  logic              blur_we;
  row_u              blur_din;
  row_u              img_dout  = '0;
  row_u              blur_dout = '0;

  row_u        img_mem  [MEM_DEPTH];
  row_u        blur_mem [MEM_DEPTH];
  row_u        expect_rows [IMG_H];
  logic        fill_ones;
  logic        fill_blur;
  logic        busy;
  logic [31:0] rng;
  // each file image has IMG_H source rows followed by IMG_H expected rows
  logic [$bits(row_u)-1:0] test_rows [4*IMG_H];
  int          errors;
  int          runs;
  int          tests_run;
  int          idle_errors = 0;
  int          done_count  = 0;

  gaussian_blur #(
    .IMG_W    (IMG_W),
    .IMG_H    (IMG_H),
    .STRIP_PX (STRIP_PX)
  ) gaussian_blur_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .done      (done),
    .img_addr  (img_addr),
    .img_dout  (img_dout),
    .blur_addr (blur_addr),
    .blur_we   (blur_we),
    .blur_din  (blur_din),
    .blur_dout (blur_dout)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  // both memories answer one cycle after the address
  always @(posedge clk) begin
    img_dout  <= img_mem[img_addr];
    blur_dout <= blur_mem[blur_addr];
    if (fill_blur) begin
      for (int r = 0; r < MEM_DEPTH; r++) begin
        if (fill_ones) begin
          blur_mem[r] <= '1;
        end else begin
          blur_mem[r] <= addr_pattern(r);
        end
      end
    end else if (blur_we) begin
      blur_mem[blur_addr] <= blur_din;
    end
  end

  // count done pulses and flag activity outside a run
  always @(posedge clk) begin
    if (rst_n && done) begin
      done_count <= done_count + 1;
    end
    if (rst_n && !busy && (done || blur_we)) begin
      $display("ERROR: time %0t: done or blur_we went high while idle", $time);
      idle_errors <= idle_errors + 1;
    end
  end

  initial begin
    #(WATCHDOG_TIME);
    $display("ERROR: watchdog expired at time %0t, the engine never finished", $time);
    $display("Simulation failed");
    $finish;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // pixel value tracks the row address and is never zero
  function automatic row_u addr_pattern(input int a);
    row_u res;
    for (int c = 0; c < IMG_W; c++) begin
      res.px[c] = pixel_t'(a * 32 + c + 1);
    end
    return res;
  endfunction

  function automatic int hex_digit(input byte ch);
    if (ch >= "0" && ch <= "9") begin
      return ch - "0";
    end
    if (ch >= "a" && ch <= "f") begin
      return ch - "a" + 10;
    end
    if (ch >= "A" && ch <= "F") begin
      return ch - "A" + 10;
    end
    return -1;
  endfunction

  // one hex row per line with any spaces skipped
  task automatic read_test_rows();
    int                      fd;
    int                      n;
    int                      nd;
    int                      d;
    string                   text;
    logic [$bits(row_u)-1:0] word;
    n  = 0;
    fd = $fopen("sim/blur_testdata.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("ERROR: could not open the test data file sim/blur_testdata.txt");
    end else begin
      while (!$feof(fd) && n < 4 * IMG_H) begin
        text = "";
        void'($fgets(text, fd));
        word = '0;
        nd   = 0;
        for (int i = 0; i < text.len(); i++) begin
          if (text[i] == "/") begin
            break;
          end
          d = hex_digit(text[i]);
          if (d >= 0) begin
            word = {word[$bits(row_u)-5:0], 4'(d)};
            nd++;
          end
        end
        if (nd > 0) begin
          test_rows[n] = word;
          n++;
        end
      end
      $fclose(fd);
      if (n != 4 * IMG_H) begin
        errors++;
        $display("ERROR: test data holds %0d rows, expected %0d", n, 4 * IMG_H);
      end
    end
  endtask

  // zero padding outside the image
  function automatic int pixel_at(input int r, input int c);
    if (r < 0 || r >= IMG_H || c < 0 || c >= IMG_W) begin
      return 0;
    end
    return int'(img_mem[r].px[c]);
  endfunction

  function automatic row_u blurred_row(input int r);
    row_u res;
    int   acc;
    res = '0;
    for (int c = 0; c < IMG_W; c++) begin
      acc = 8;
      for (int dr = -1; dr <= 1; dr++) begin
        for (int dc = -1; dc <= 1; dc++) begin
          acc = acc + (dr == 0 ? 2 : 1) * (dc == 0 ? 2 : 1) * pixel_at(r + dr, c + dc);
        end
      end
      res.px[c] = pixel_t'(acc >> 4);
    end
    return res;
  endfunction

  task automatic check_row(input row_u got, input row_u exp, input int row);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH time %0t: row %0d got %h expected %h", $time, row, got, exp);
    end
  endtask

  task automatic check_done(input int got, input int exp);
    if (got != exp) begin
      errors++;
      $display("MISMATCH time %0t: %0d done pulses, expected %0d", $time, got, exp);
    end
  endtask

  task automatic run_blur();
    int waited;
    waited = 0;
    @(posedge clk);
    #1;
    start = 1'b1;
    busy  = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
    @(negedge clk);
    while (!done && waited < 2 * RUN_CYCLES) begin
      @(negedge clk);
      waited++;
    end
    if (!done) begin
      errors++;
      $display("ERROR: time %0t: no done pulse within %0d cycles", $time, 2 * RUN_CYCLES);
    end
    @(posedge clk);
    #1;
    busy = 1'b0;
  endtask

  task automatic run_test(input string name);
    int fails_before;
    fails_before = errors + idle_errors;
    for (int round = 0; round < 2; round++) begin
      // second round starts from an all ones blur memory
      @(posedge clk);
      #1;
      fill_blur = 1'b1;
      fill_ones = (round != 0);
      @(posedge clk);
      #1;
      fill_blur = 1'b0;
      run_blur();
      runs++;
      repeat (4) @(negedge clk);
      check_done(done_count, runs);
      for (int r = 0; r < IMG_H; r++) begin
        check_row(blur_mem[r], expect_rows[r], r);
      end
    end
    tests_run++;
    if (errors + idle_errors == fails_before) $display("test %s: ok", name);
    else $display("test %s: FAILED", name);
  endtask

  initial begin
    rst_n     = 1'b0;
    start     = 1'b0;
    fill_blur = 1'b0;
    fill_ones = 1'b0;
    busy      = 1'b0;
    errors    = 0;
    runs      = 0;
    tests_run = 0;
    rng       = 32'h433;
    // rows below the image are nonzero so the bottom zero fill is exercised
    for (int r = 0; r < MEM_DEPTH; r++) begin
      img_mem[r] = addr_pattern(r);
    end
    read_test_rows();
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // quiet period in which the monitor catches any stray done or write
    repeat (6) @(negedge clk);
    check_done(done_count, 0);

    for (int t = 0; t < 2; t++) begin
      for (int r = 0; r < IMG_H; r++) begin
        img_mem[r]     = test_rows[2*IMG_H*t + r];
        expect_rows[r] = test_rows[2*IMG_H*t + IMG_H + r];
      end
      run_test($sformatf("file_image_%0d", t));
    end

    for (int r = 0; r < IMG_H; r++) begin
      for (int c = 0; c < IMG_W; c++) begin
        rng = xorshift32(rng);
        img_mem[r].px[c] = rng[7:0];
      end
    end
    for (int r = 0; r < IMG_H; r++) begin
      expect_rows[r] = blurred_row(r);
    end
    run_test("random_image");

    repeat (8) @(negedge clk);
    check_done(done_count, runs);
    $display("tests run %0d, failed checks %0d", tests_run, errors + idle_errors);
    if (errors + idle_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- hw/gaussian_blur.sv
module gaussian_blur #(
  parameter int IMG_W    = blur_pkg::IMG_W,
  parameter int IMG_H    = blur_pkg::IMG_H,
  parameter int STRIP_PX = blur_pkg::STRIP_PX
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       start,
  output logic                       done,
  output logic [$clog2(IMG_H+1)-1:0] img_addr,
  input  blur_pkg::row_u             img_dout,
  output logic [$clog2(IMG_H+1)-1:0] blur_addr,
  output logic                       blur_we,
  output blur_pkg::row_u             blur_din,
  input  blur_pkg::row_u             blur_dout
);
  import blur_pkg::*;

  localparam int STRIPS  = IMG_W / STRIP_PX;
  localparam int STRIP_W = $clog2(STRIPS);

  logic               row_clr;
  logic               row_inc;
  logic               strip_clr;
  logic               strip_inc;
  logic               win_shift;
  logic               kern_en;
  logic               last_row;
  logic               last_strip;
  logic               load_row_valid;
  logic [STRIP_W-1:0] strip_idx;
  window_t            window;
  strip_t             blur_out;

  blur_fsm blur_fsm_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .last_row   (last_row),
    .last_strip (last_strip),
    .done       (done),
    .row_clr    (row_clr),
    .row_inc    (row_inc),
    .strip_clr  (strip_clr),
    .strip_inc  (strip_inc),
    .win_shift  (win_shift),
    .kern_en    (kern_en),
    .blur_we    (blur_we)
  );

  // blur rows are addressed by row_idx, image rows by the one below it
  scan_counter #(
    .IMG_H  (IMG_H),
    .STRIPS (STRIPS)
  ) scan_counter_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .row_clr        (row_clr),
    .row_inc        (row_inc),
    .strip_clr      (strip_clr),
    .strip_inc      (strip_inc),
    .row_idx        (blur_addr),
    .load_idx       (img_addr),
    .strip_idx      (strip_idx),
    .last_row       (last_row),
    .last_strip     (last_strip),
    .load_row_valid (load_row_valid)
  );

  line_buffer #(
    .IMG_W    (IMG_W),
    .STRIP_PX (STRIP_PX)
  ) line_buffer_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .win_shift      (win_shift),
    .load_row_valid (load_row_valid),
    .strip_idx      (strip_idx),
    .img_dout       (img_dout),
    .row_clr        (row_clr),
    .window         (window)
  );

  gauss_3x3 gauss_3x3_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .kern_en  (kern_en),
    .window   (window),
    .blur_out (blur_out)
  );

  strip_merge #(
    .IMG_W    (IMG_W),
    .STRIP_PX (STRIP_PX)
  ) strip_merge_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .strip_idx (strip_idx),
    .blur_out  (blur_out),
    .blur_dout (blur_dout),
    .blur_din  (blur_din)
  );

endmodule

//--- hw/strip_merge.sv
module strip_merge #(
  parameter int IMG_W    = blur_pkg::IMG_W,
  parameter int STRIP_PX = blur_pkg::STRIP_PX
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic [$clog2(IMG_W/STRIP_PX)-1:0]  strip_idx,
  input  blur_pkg::strip_t                   blur_out,
  input  blur_pkg::row_u                     blur_dout,
  output blur_pkg::row_u                     blur_din
);

  localparam int STRIPS = IMG_W / STRIP_PX;

  // lower strips kept, current strip replaced, upper strips cleared
  always_comb begin
    blur_din = '0;
    for (int s = 0; s < STRIPS; s++) begin
      if (s < int'(strip_idx)) begin
        blur_din.strips[s] = blur_dout.strips[s];
      end else if (s == int'(strip_idx)) begin
        blur_din.strips[s] = blur_out;
      end
    end
  end

  // strips arrive left to right, so every lower strip is already written
  a_strip_order: assert property (
    @(posedge clk) disable iff (!rst_n)
      $changed(strip_idx) |->
        (strip_idx == $past(strip_idx) + 1'b1) || (strip_idx == '0)
  );

endmodule

//--- hw/gauss_3x3.sv
module gauss_3x3 (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              kern_en,
  input  blur_pkg::window_t window,
  output blur_pkg::strip_t  blur_out
);
  import blur_pkg::*;

  // window line as a flat pixel array, index 0 is the left neighbor
  typedef pixel_t [STRIP_PX+1:0] ext_row_t;

  strip_t blur_next;

  // 1 2 1 along one line, centred on pixel i+1
  function automatic logic [9:0] tap_row(ext_row_t r, int i);
    return 10'(r[i]) + 10'({r[i+1], 1'b0}) + 10'(r[i+2]);
  endfunction

  always_comb begin
    ext_row_t    t_row;
    ext_row_t    m_row;
    ext_row_t    b_row;
    logic [11:0] acc;
    t_row = ext_row_t'(window.top);
    m_row = ext_row_t'(window.mid);
    b_row = ext_row_t'(window.bot);
    for (int i = 0; i < STRIP_PX; i++) begin
      // weights sum to 16, +8 rounds to nearest
      acc = 12'(tap_row(t_row, i)) + 12'({tap_row(m_row, i), 1'b0})
          + 12'(tap_row(b_row, i)) + 12'd8;
      blur_next.px[i] = acc[11:4];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      blur_out <= '0;
    end else if (kern_en) begin
      blur_out <= blur_next;
    end
  end

endmodule

//--- hw/line_buffer.sv
module line_buffer #(
  parameter int IMG_W    = blur_pkg::IMG_W,
  parameter int STRIP_PX = blur_pkg::STRIP_PX
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               win_shift,
  input  logic                               load_row_valid,
  input  logic [$clog2(IMG_W/STRIP_PX)-1:0]  strip_idx,
  input  blur_pkg::row_u                     img_dout,
  input  logic                               row_clr,
  output blur_pkg::window_t                  window
);
  import blur_pkg::*;

  localparam int STRIPS = IMG_W / STRIP_PX;

  window_row_t new_row;

  // strip slice of the incoming row, zero outside the image
  always_comb begin
    int base;
    base    = int'(strip_idx) * STRIP_PX;
    new_row = '0;
    if (load_row_valid) begin
      for (int i = 0; i < STRIP_PX; i++) begin
        new_row.core.px[i] = img_dout.px[base + i];
      end
      if (strip_idx != '0) begin
        new_row.left = img_dout.px[base - 1];
      end
      if (int'(strip_idx) != STRIPS - 1) begin
        new_row.right = img_dout.px[base + STRIP_PX];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (row_clr) begin
      window <= '0;
    end else if (win_shift) begin
      window.top <= window.mid;
      window.mid <= window.bot;
      window.bot <= new_row;
    end
  end

  // a zero row goes in only below the last image row,
  // whose write rewinds the row counter two cycles later
  a_zero_row_last: assert property (
    @(posedge clk) disable iff (!rst_n)
      win_shift && !load_row_valid |-> ##2 row_clr
  );

endmodule

//--- hw/blur_fsm.sv
module blur_fsm (
  input  logic clk,
  input  logic rst_n,
  input  logic start,
  input  logic last_row,
  input  logic last_strip,
  output logic done,
  output logic row_clr,
  output logic row_inc,
  output logic strip_clr,
  output logic strip_inc,
  output logic win_shift,
  output logic kern_en,
  output logic blur_we
);
  import blur_pkg::*;

  blur_state_t state;
  blur_state_t state_next;
  // second cycle of the two-cycle prime
  logic        prime_second;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state        <= IDLE;
      prime_second <= 1'b0;
    end else begin
      state        <= state_next;
      prime_second <= (state == PRIME) && !prime_second;
    end
  end

  always_comb begin
    state_next = state;
    unique case (state)
      IDLE: begin
        if (start) begin
          state_next = PRIME;
        end
      end
      PRIME: begin
        if (prime_second) begin
          state_next = LOAD;
        end
      end
      LOAD:  state_next = SHIFT;
      SHIFT: state_next = BLUR;
      BLUR:  state_next = WRITE;
      WRITE: begin
        if (!last_row) begin
          state_next = LOAD;
        end else if (last_strip) begin
          state_next = DONE;
        end else begin
          state_next = PRIME;
        end
      end
      DONE:    state_next = IDLE;
      default: state_next = IDLE;
    endcase
  end

  // counters rewind on start and after the last row of every strip
  assign row_clr   = (state == IDLE && start) || (state == WRITE && last_row);
  assign strip_clr = (state == IDLE && start);
  assign strip_inc = (state == WRITE) && last_row && !last_strip;
  // first step happens when row 0 is captured in prime
  assign row_inc   = (state == PRIME && prime_second) || (state == WRITE && !last_row);
  assign win_shift = (state == PRIME && prime_second) || (state == SHIFT);
  assign kern_en   = (state == BLUR);
  assign blur_we   = (state == WRITE);
  assign done      = (state == DONE);

  // strip counter moves only when a strip ends or a scan starts
  a_strip_step: assert property (
    @(posedge clk) disable iff (!rst_n) $changed(last_strip) |-> $past(row_clr)
  );

endmodule

//--- hw/scan_counter.sv
module scan_counter #(
  parameter int IMG_H  = blur_pkg::IMG_H,
  parameter int STRIPS = blur_pkg::IMG_W / blur_pkg::STRIP_PX
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        row_clr,
  input  logic                        row_inc,
  input  logic                        strip_clr,
  input  logic                        strip_inc,
  output logic [$clog2(IMG_H+1)-1:0]  row_idx,
  output logic [$clog2(IMG_H+1)-1:0]  load_idx,
  output logic [$clog2(STRIPS)-1:0]   strip_idx,
  output logic                        last_row,
  output logic                        last_strip,
  output logic                        load_row_valid
);

  localparam int ROW_W   = $clog2(IMG_H + 1);
  localparam int STRIP_W = $clog2(STRIPS);

  // all ones marks the slot before row 0, so load_idx points at row 0 in prime
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      row_idx <= '1;
    end else if (row_clr) begin
      row_idx <= '1;
    end else if (row_inc) begin
      row_idx <= row_idx + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      strip_idx <= '0;
    end else if (strip_clr) begin
      strip_idx <= '0;
    end else if (strip_inc) begin
      strip_idx <= strip_idx + 1'b1;
    end
  end

  assign load_idx       = row_idx + 1'b1;
  assign load_row_valid = load_idx < ROW_W'(IMG_H);
  assign last_row       = row_idx == ROW_W'(IMG_H - 1);
  assign last_strip     = strip_idx == STRIP_W'(STRIPS - 1);

  // fsm never steps past the last strip
  a_strip_in_range: assert property (
    @(posedge clk) disable iff (!rst_n) strip_inc |-> !last_strip
  );

endmodule

//--- hw/blur_pkg.sv
package blur_pkg;

  localparam int PIX_W = 8;

  // default geometry, the top level overrides it through its parameters
  localparam int IMG_W    = 16;
  localparam int IMG_H    = 6;
  localparam int STRIP_PX = 4;

  typedef logic [PIX_W-1:0] pixel_t;

  // pixel 0 in the low byte
  typedef struct packed {
    pixel_t [STRIP_PX-1:0] px;
  } strip_t;

  // one window line: strip plus one neighbor pixel each side
  typedef struct packed {
    pixel_t right;
    strip_t core;
    pixel_t left;
  } window_row_t;

  // three consecutive image rows of the current strip
  typedef struct packed {
    window_row_t top;
    window_row_t mid;
    window_row_t bot;
  } window_t;

  // full memory row, seen per pixel or per strip
  typedef union packed {
    pixel_t [IMG_W-1:0]          px;
    strip_t [IMG_W/STRIP_PX-1:0] strips;
  } row_u;

  typedef enum logic [2:0] {
    IDLE,
    PRIME,
    LOAD,
    SHIFT,
    BLUR,
    WRITE,
    DONE
  } blur_state_t;

endpackage
